// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= acq_tb
FLIST     ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= ** PASS **
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) \
		-Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) | tee $(LOG)
	grep -qxF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== acq_asserts.sv ====
// chain flow control assertions
`timescale 1ns/1ps
`include "acq_consts.svh"

module acq_asserts (
  input logic                                      clk,
  input logic                                      rst,
  input logic                                      in_push,   // input buffer write
  input logic                                      mid_push,  // middle buffer write
  input logic                                      out_vld,
  input logic [$clog2(`ACQ_FIFO_DEPTH + 1)-1:0]    in_cnt,    // fill counts
  input logic [$clog2(`ACQ_FIFO_DEPTH + 1)-1:0]    mid_cnt,
  input logic [$clog2(`ACQ_FIFO_DEPTH + 1)-1:0]    corr_crd,  // credit counters
  input logic [$clog2(`ACQ_OUT_CREDITS + 1)-1:0]   dec_crd
);

  ////////////////////////////////////////
  // overflow and credit range
  ////////////////////////////////////////

  in_no_ovf: assert property (@(posedge clk) disable iff (rst)
    in_push |-> in_cnt < `ACQ_FIFO_DEPTH) else $error("input buffer written while full");
  mid_no_ovf: assert property (@(posedge clk) disable iff (rst)
    mid_push |-> mid_cnt < `ACQ_FIFO_DEPTH) else $error("middle buffer written while full");
  corr_rng: assert property (@(posedge clk) disable iff (rst)
    corr_crd <= `ACQ_FIFO_DEPTH) else $error("corrector credit count out of range");
  dec_rng: assert property (@(posedge clk) disable iff (rst)
    dec_crd <= `ACQ_OUT_CREDITS) else $error("decimator credit count out of range");
  // output needs a credit held the cycle before
  out_crd_held: assert property (@(posedge clk) disable iff (rst)
    out_vld |-> $past(dec_crd) != '0) else $error("output sent without sink credit");

endmodule : acq_asserts

bind acq_chain_top acq_asserts i_asserts (
  .clk, .rst, .in_push(in.vld), .mid_push(mid_wr.vld), .out_vld(out.vld),
  .in_cnt(i_in_fifo.cnt), .mid_cnt(i_mid_fifo.cnt),
  .corr_crd(i_corr.crd_cnt), .dec_crd(i_dec.crd_cnt)
);

// ==== acq_chain_top.sv ====
// acquisition chain top level
`timescale 1ns/1ps
`include "acq_consts.svh"

module acq_chain_top (
  input  logic             clk,
  input  logic             rst,
  input  acq_pkg::stream_t in,       // from outside source
  output logic             in_crd,
  output acq_pkg::stream_t out,      // to outside sink
  input  logic             out_crd,
  input  acq_pkg::cfg_op_e cfg_op,
  input  logic [15:0]      cfg_dat
);

  acq_pkg::stream_t in_head;   // input buffer head
  acq_pkg::stream_t mid_wr;    // corrector result
  acq_pkg::stream_t mid_head;  // middle buffer head
  logic             in_pop;
  logic             mid_pop;
  logic             mid_crd;
  acq_pkg::cfg_t    cfg;

  ////////////////////////////////////////
  // configuration
  ////////////////////////////////////////

  cfg_regs i_cfg (.clk, .rst, .cfg_op, .cfg_dat, .cfg);

  ////////////////////////////////////////
  // data path
  ////////////////////////////////////////

  credit_fifo #(.depth(`ACQ_FIFO_DEPTH)) i_in_fifo (
    .clk, .rst, .wr(in), .crd(in_crd), .pop(in_pop), .head(in_head)
  );

  correction_linear i_corr (
    .clk, .rst, .head(in_head), .pop(in_pop), .sto(mid_wr), .sto_crd(mid_crd), .cfg
  );

  credit_fifo #(.depth(`ACQ_FIFO_DEPTH)) i_mid_fifo (
    .clk, .rst, .wr(mid_wr), .crd(mid_crd), .pop(mid_pop), .head(mid_head)
  );

  decimator_avg i_dec (
    .clk, .rst, .head(mid_head), .pop(mid_pop), .out, .out_crd, .cfg
  );

endmodule : acq_chain_top

// ==== acq_consts.svh ====
// acquisition chain constants
`ifndef ACQ_CONSTS_SVH
`define ACQ_CONSTS_SVH

////////////////////////////////////////
// data path widths
////////////////////////////////////////

`define ACQ_DW   14  // adc sample width, signed
`define ACQ_GW   16  // gain width, unsigned
`define ACQ_FRAC 14  // gain fraction bits, 16384 is unity

////////////////////////////////////////
// buffering and flow control
////////////////////////////////////////

`define ACQ_FIFO_DEPTH  4  // entries per buffer, also writer's initial credits
`define ACQ_OUT_CREDITS 2  // credits toward the outside sink

// decimation block is 2**shift samples
`define ACQ_MAX_SHIFT 3

`endif

// ==== acq_pkg.sv ====
// acquisition chain types
`include "acq_consts.svh"

package acq_pkg;

  ////////////////////////////////////////
  // data link
  ////////////////////////////////////////

  typedef struct packed {
    logic                     vld;  // one cycle per sample
    logic signed [`ACQ_DW-1:0] dat;  // signed sample
  } stream_t;

  ////////////////////////////////////////
  // configuration
  ////////////////////////////////////////

  typedef struct packed {
    logic        [`ACQ_GW-1:0] gain;   // u2.14
    logic signed [`ACQ_DW-1:0] off;    // added after gain
    logic        [1:0]         shift;  // log2 of block length
  } cfg_t;

  // register write opcodes
  typedef enum logic [1:0] {
    CFG_NOP   = 2'd0,
    CFG_GAIN  = 2'd1,
    CFG_OFF   = 2'd2,
    CFG_SHIFT = 2'd3
  } cfg_op_e;

endpackage : acq_pkg

// ==== acq_tb.sv ====
// acquisition chain testbench
`timescale 1ns/1ps
`include "acq_consts.svh"

module acq_tb;

  localparam int n_tests     = 6;
  localparam int n_samp      = 200;  // samples per test, upper bound
  localparam int half_period = 2;    // 4 ns clock
  localparam int dw          = `ACQ_DW;
  localparam int s_max       = (1 << (`ACQ_DW - 1)) - 1;
  localparam int s_min       = -(1 << (`ACQ_DW - 1));

  logic             clk;
  logic             rst;
  acq_pkg::stream_t in;
  logic             in_crd;
  acq_pkg::stream_t out;
  logic             out_crd = 1'b0;
  acq_pkg::cfg_op_e cfg_op;
  logic [15:0]      cfg_dat;

  int    exp_q[$];        // expected outputs, indexed by outs
  int    blk_sum = 0;     // model block in progress
  int    blk_n = 0;
  int    m_gain = 16384;  // model copy of the config
  int    m_off = 0;
  int    m_shift = 0;
  int    sent = 0;        // source side
  int    crd_back = 0;
  int    outs = 0;        // sink side
  int    crd_given = 0;
  int    hold_left = 0;   // sink withholds credits while nonzero
  int    hold_pct = 0;
  int    mon_err = 0;
  int    drv_err = 0;
  int    m_checks = 0;
  int    d_checks = 0;
  int    n_run = 0;
  int    n_fail = 0;
  int    t_err0 = 0;
  string t_name = "reset";

  acq_chain_top i_dut (.clk, .rst, .in, .in_crd, .out, .out_crd, .cfg_op, .cfg_dat);

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  function automatic void model_push(input int x);
    longint p;
    int     c;
    p = longint'(x) * m_gain;
    c = int'(p >>> `ACQ_FRAC) + m_off;  // floor divide, then offset
    c = (c > s_max) ? s_max : (c < s_min) ? s_min : c;
    blk_sum += c;
    blk_n++;
    if (blk_n == (1 << m_shift)) begin
      exp_q.push_back(blk_sum >>> m_shift);  // floor average
      blk_sum = 0;
      blk_n = 0;
    end
  endfunction

  // source, sends only while holding credit
  task automatic run_samples(input int n, input int idle_pct);
    int k;
    logic signed [`ACQ_DW-1:0] x;
    k = 0;
    while (k < n) begin
      @(posedge clk);
      if (`ACQ_FIFO_DEPTH + crd_back - sent > 0 && $urandom_range(99) >= idle_pct) begin
        x = dw'($urandom);
        in <= '{vld: 1'b1, dat: x};
        sent++;
        model_push(int'(x));
        k++;
      end else begin
        in <= '0;
      end
    end
    @(posedge clk);
    in <= '0;
  endtask

  // waits for every expected output, then checks source credits are home
  task automatic drain();
    while (exp_q.size() != outs || crd_given != outs) begin
      @(negedge clk);  // sink counters settled mid cycle
    end
    repeat (6) @(posedge clk);
    d_checks++;
    assert (sent == crd_back) else begin
      $display("ERR %s expected %0d got %0d", t_name, `ACQ_FIFO_DEPTH,
               `ACQ_FIFO_DEPTH + crd_back - sent);
      drv_err++;
    end
  endtask

  task automatic write_reg(input acq_pkg::cfg_op_e op, input logic [15:0] dat);
    @(posedge clk);
    cfg_op  <= op;
    cfg_dat <= dat;
    @(posedge clk);
    cfg_op  <= acq_pkg::CFG_NOP;
  endtask

  task automatic set_cfg(input int gain, input int off, input int shift);
    drain();  // config only on an empty chain
    write_reg(acq_pkg::CFG_GAIN, 16'(gain));
    write_reg(acq_pkg::CFG_OFF, 16'(off));
    write_reg(acq_pkg::CFG_SHIFT, 16'(shift));
    m_gain  = gain;
    m_off   = off;
    m_shift = shift;
  endtask

  task automatic start_test(input string name);
    t_name = name;
    t_err0 = mon_err + drv_err;
  endtask

  task automatic end_test();
    int n;
    drain();
    n = mon_err + drv_err - t_err0;
    n_run++;
    if (n != 0) begin
      n_fail++;
    end
    $display("test %-14s %s, %0d errors", t_name, (n == 0) ? "ok" : "failed", n);
  endtask

  ////////////////////////////////////////
  // sink and output monitor
  ////////////////////////////////////////

  always @(posedge clk) begin
    if (rst) begin
      out_crd <= 1'b0;
    end else begin
      out_crd <= 1'b0;
      if (hold_left > 0) begin
        hold_left--;  // long stretch without credits
      end else if (outs > crd_given && $urandom_range(99) < 50) begin
        out_crd <= 1'b1;
        crd_given++;
        if ($urandom_range(99) < hold_pct) begin
          hold_left = $urandom_range(80, 20);
        end
      end
    end
  end

  always @(negedge clk) begin  // mid cycle, outputs settled
    if (!rst) begin
      if (in_crd) begin
        crd_back++;
      end
      if (out.vld) begin
        m_checks++;
        assert (outs < exp_q.size()) else begin
          $display("output in test %s arrived with no sample left to expect", t_name);
          mon_err++;
        end
        if (outs < exp_q.size()) begin
          assert (int'(out.dat) == exp_q[outs]) else begin
            $display("ERR %s expected %0d got %0d", t_name, exp_q[outs], out.dat);
            mon_err++;
          end
        end
        outs++;
        assert (outs <= crd_given + `ACQ_OUT_CREDITS) else begin
          $display("sink overrun, %0d outputs against %0d credits", outs, crd_given);
          mon_err++;
        end
      end
    end
  end

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin
    void'($urandom(32'h7deb));
    rst     <= 1'b1;
    in      <= '0;
    cfg_op  <= acq_pkg::CFG_NOP;
    cfg_dat <= '0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    start_test("passthrough");
    set_cfg(1 << `ACQ_FRAC, 0, 0);
    run_samples(n_samp, 20);
    end_test();

    start_test("gain_offset");  // gains up to about 2.4
    repeat (4) begin
      set_cfg($urandom_range(40000, 4096), int'($urandom_range(4000)) - 2000, 0);
      run_samples(n_samp / 4, 20);
    end
    end_test();

    start_test("saturation");
    set_cfg($urandom_range(65535, 49152), int'($urandom_range(s_max, 6000)), 0);
    run_samples(n_samp / 2, 10);
    set_cfg($urandom_range(65535, 49152), -int'($urandom_range(-s_min, 6000)), 0);
    run_samples(n_samp / 2, 10);
    end_test();

    start_test("decimation");  // 64 is whole blocks for every shift
    for (int s = 1; s <= `ACQ_MAX_SHIFT; s++) begin
      set_cfg(1 << `ACQ_FRAC, int'($urandom_range(2000)) - 1000, s);
      run_samples(64, 20);
    end
    end_test();

    start_test("backpressure");
    set_cfg(1 << `ACQ_FRAC, 0, 1);
    hold_pct = 60;
    run_samples(n_samp, 10);
    end_test();
    hold_pct = 0;

    start_test("input_credits");  // source at full rate
    set_cfg(1 << `ACQ_FRAC, 0, 0);
    run_samples(n_samp, 0);
    end_test();

    $display("tests %0d, failed %0d, checks %0d, errors %0d", n_run, n_fail,
             m_checks + d_checks, mon_err + drv_err);
    if (mon_err + drv_err == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // watchdog, 20 cycles per sample
  initial begin
    #(longint'(n_tests) * n_samp * 20 * 2 * half_period);
    $display("timeout, the run did not finish after %0d tests", n_run);
    $display("** FAIL **");
    $finish;
  end

endmodule : acq_tb

// ==== cfg_regs.sv ====
// configuration register block
`timescale 1ns/1ps
`include "acq_consts.svh"

module cfg_regs (
  input  logic             clk,
  input  logic             rst,
  input  acq_pkg::cfg_op_e cfg_op,   // write opcode, nop when idle
  input  logic [15:0]      cfg_dat,  // write data
  output acq_pkg::cfg_t    cfg       // held configuration
);

  // unity gain after reset
  localparam logic [`ACQ_GW-1:0] gain_unity = `ACQ_GW'(1) << `ACQ_FRAC;

  ////////////////////////////////////////
  // opcode decode
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      cfg.gain  <= gain_unity;
      cfg.off   <= '0;
      cfg.shift <= '0;
    end else begin
      case (cfg_op)
        acq_pkg::CFG_GAIN: begin
          cfg.gain <= cfg_dat;  // full word
        end
        acq_pkg::CFG_OFF: begin
          cfg.off <= $signed(cfg_dat[`ACQ_DW-1:0]);  // low bits, two's complement
        end
        acq_pkg::CFG_SHIFT: begin
          cfg.shift <= cfg_dat[1:0];
        end
        default: begin
          // nop keeps everything
        end
      endcase
    end
  end

endmodule : cfg_regs

// ==== correction_linear.sv ====
// linear gain offset saturation
`timescale 1ns/1ps
`include "acq_consts.svh"

module correction_linear (
  input  logic             clk,
  input  logic             rst,
  input  acq_pkg::stream_t head,     // input buffer head
  output logic             pop,      // take head
  output acq_pkg::stream_t sto,      // toward middle buffer
  input  logic             sto_crd,  // credit back from middle buffer
  input  acq_pkg::cfg_t    cfg
);

  localparam int unsigned pw  = `ACQ_DW + `ACQ_GW + 1;      // signed x times unsigned gain
  localparam int unsigned sw  = pw - `ACQ_FRAC + 1;         // after shift, one guard bit
  localparam int unsigned ccw = $clog2(`ACQ_FIFO_DEPTH + 1);

  logic [ccw-1:0]            crd_cnt;  // free entries downstream
  logic                      v1, v2, v3;
  logic signed [pw-1:0]      mul;      // stage 1
  logic signed [sw-1:0]      sum;      // stage 2
  logic signed [`ACQ_DW-1:0] d3;       // stage 3
  logic signed [pw-`ACQ_FRAC-1:0] mul_sh;
  logic                      in_rng;

  // credit reserved at pop, so the pipe never stalls
  assign pop = head.vld & (crd_cnt != '0);

  ////////////////////////////////////////
  // credit counter
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      crd_cnt <= ccw'(`ACQ_FIFO_DEPTH);
    end else begin
      case ({pop, sto_crd})
        2'b10:   crd_cnt <= crd_cnt - 1'b1;
        2'b01:   crd_cnt <= crd_cnt + 1'b1;
        default: crd_cnt <= crd_cnt;  // send and return cancel
      endcase
    end
  end

  // valid bits travel alongside the data
  always_ff @(posedge clk) begin
    if (rst) begin
      v1 <= 1'b0;
      v2 <= 1'b0;
      v3 <= 1'b0;
    end else begin
      v1 <= pop;
      v2 <= v1;
      v3 <= v2;
    end
  end

  // floor divide by 2**frac, arithmetic
  assign mul_sh = mul[pw-1:`ACQ_FRAC];

  // sum fits when all bits above the sample sign agree
  assign in_rng = (&sum[sw-1:`ACQ_DW-1]) | ~(|sum[sw-1:`ACQ_DW-1]);

  ////////////////////////////////////////
  // data stages
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    mul <= head.dat * $signed({1'b0, cfg.gain});       // gain
    sum <= sw'(mul_sh) + sw'(cfg.off);                 // offset, sign extended
    if (in_rng) begin
      d3 <= sum[`ACQ_DW-1:0];
    end else begin
      d3 <= {sum[sw-1], {(`ACQ_DW-1){~sum[sw-1]}}};   // clamp to 8191 or -8192
    end
  end

  assign sto.vld = v3;
  assign sto.dat = d3;

endmodule : correction_linear

// ==== credit_fifo.sv ====
// credit returning receive buffer
`timescale 1ns/1ps
`include "acq_consts.svh"

module credit_fifo #(
  parameter int unsigned depth = `ACQ_FIFO_DEPTH  // 2 or more
) (
  input  logic              clk,
  input  logic              rst,
  input  acq_pkg::stream_t  wr,    // write side, never full by credit
  output logic              crd,   // one pulse per freed entry
  input  logic              pop,   // read side
  output acq_pkg::stream_t  head   // first word fall-through
);

  localparam int unsigned pw = $clog2(depth);
  localparam int unsigned cw = $clog2(depth + 1);

  logic signed [`ACQ_DW-1:0] mem [depth];  // sample storage only
  logic [pw-1:0]             wr_ptr;
  logic [pw-1:0]             rd_ptr;
  logic [cw-1:0]             cnt;         // fill count
  logic                      do_pop;

  assign do_pop = pop & head.vld;  // popping empty is ignored
  assign crd    = do_pop;          // credit goes back with the pop

  assign head.vld = (cnt != '0);
  assign head.dat = mem[rd_ptr];

  // payload write, no reset
  always_ff @(posedge clk) begin
    if (wr.vld) begin
      mem[wr_ptr] <= wr.dat;
    end
  end

  ////////////////////////////////////////
  // pointers and fill count
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end else begin
      if (wr.vld) begin
        wr_ptr <= (wr_ptr == pw'(depth - 1)) ? '0 : wr_ptr + 1'b1;  // wrap for any depth
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == pw'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr.vld, do_pop})
        2'b10:   cnt <= cnt + 1'b1;
        2'b01:   cnt <= cnt - 1'b1;
        default: cnt <= cnt;  // idle or push with pop
      endcase
    end
  end

endmodule : credit_fifo

// ==== decimator_avg.sv ====
// block averaging decimator
`timescale 1ns/1ps
`include "acq_consts.svh"

module decimator_avg (
  input  logic             clk,
  input  logic             rst,
  input  acq_pkg::stream_t head,     // middle buffer head
  output logic             pop,
  output acq_pkg::stream_t out,      // toward outside sink
  input  logic             out_crd,  // sink credit return
  input  acq_pkg::cfg_t    cfg
);

  localparam int unsigned aw  = `ACQ_DW + `ACQ_MAX_SHIFT;   // sum of 8 samples
  localparam int unsigned cw  = `ACQ_MAX_SHIFT + 1;         // counts up to block length
  localparam int unsigned ccw = $clog2(`ACQ_OUT_CREDITS + 1);

  logic [ccw-1:0]            crd_cnt;  // sink credits
  logic [cw-1:0]             cnt;      // samples taken in this block
  logic signed [aw-1:0]      acc;
  logic signed [aw-1:0]      sum_nxt;  // acc plus current head
  logic signed [aw-1:0]      avg;
  logic                      last;     // head closes the block
  logic                      o_vld;
  logic signed [`ACQ_DW-1:0] o_dat;

  assign last    = ((cnt + 1'b1) == (cw'(1) << cfg.shift));
  assign sum_nxt = acc + aw'(head.dat);
  assign avg     = sum_nxt >>> cfg.shift;  // floor average

  // only a closing sample needs a sink credit
  assign pop = head.vld & (~last | (crd_cnt != '0));

  ////////////////////////////////////////
  // accumulate and emit
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      acc   <= '0;
      cnt   <= '0;
      o_vld <= 1'b0;
    end else begin
      o_vld <= pop & last;  // one pulse per block
      if (pop) begin
        if (last) begin
          acc <= '0;
          cnt <= '0;
        end else begin
          acc <= sum_nxt;
          cnt <= cnt + 1'b1;
        end
      end
    end
  end

  // result payload
  always_ff @(posedge clk) begin
    if (pop & last) begin
      o_dat <= avg[`ACQ_DW-1:0];  // average always fits the sample width
    end
  end

  // credit counter toward the sink
  always_ff @(posedge clk) begin
    if (rst) begin
      crd_cnt <= ccw'(`ACQ_OUT_CREDITS);
    end else begin
      case ({pop & last, out_crd})
        2'b10:   crd_cnt <= crd_cnt - 1'b1;
        2'b01:   crd_cnt <= crd_cnt + 1'b1;
        default: crd_cnt <= crd_cnt;
      endcase
    end
  end

  assign out.vld = o_vld;
  assign out.dat = o_dat;

endmodule : decimator_avg

// ==== sim.f ====
+incdir+.
acq_pkg.sv
cfg_regs.sv
credit_fifo.sv
correction_linear.sv
decimator_avg.sv
acq_chain_top.sv
acq_asserts.sv
acq_tb.sv
